// ==== hw/mod_pkg.sv ====
`default_nettype none

package mod_pkg;

  localparam int NumSegment = 2;
  localparam int SegSelW = (NumSegment > 1) ? $clog2(NumSegment) : 1;

  localparam int SysTimeW = 57;
  localparam int TimeShift = 9; // One modulation tick is 512 system ticks
  localparam int DividendW = 48;
  localparam int DivisorW = 24;
  localparam int IdxW = 16;

  localparam int DivLatency = DividendW + 1; // Input register plus one stage per quotient bit
  localparam int IdxLatency = 2 * DivLatency + 1;
  localparam int UpdateLatency = IdxLatency + 2;
  localparam int UpdateCntW = $clog2(UpdateLatency + 1);

  typedef struct packed {
    logic [IdxW-1:0] freq_div;
    logic [IdxW-1:0] cycle; // Stored as given, the period is cycle + 1
  } seg_setting_t;

  typedef seg_setting_t [NumSegment-1:0] seg_setting_arr_t;

  typedef struct packed {
    logic [DividendW-1:0] dividend;
    logic [DivisorW-1:0] divisor;
    logic valid;
  } div_in_t;

  typedef struct packed {
    logic [DividendW-1:0] quo;
    logic [DivisorW-1:0] rem;
    logic valid;
  } div_out_t;

  typedef logic [NumSegment-1:0][IdxW-1:0] idx_arr_t;
  typedef logic [SegSelW-1:0] seg_sel_t;

endpackage

`default_nettype wire

// ==== hw/mod_settings.sv ====
`default_nettype none

module mod_settings import mod_pkg::*; (
  input  logic             CLK,
  input  logic             rst_n,
  input  logic             update_in,
  input  seg_setting_arr_t settings_in,
  output seg_setting_arr_t settings,
  output logic             update_out
);

  typedef enum logic {
    IDLE,
    LOAD
  } state_t;

  state_t state;
  logic [UpdateCntW-1:0] cnt;

  // Settings come out of reset as zero so the index pipelines settle to 0
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state      <= IDLE;
      cnt        <= '0;
      update_out <= 1'b0;
      settings   <= '0;
    end else begin
      update_out <= 1'b0;
      case (state)
        IDLE: begin
          cnt <= '0;
          if (update_in) begin
            settings <= settings_in;
            state    <= LOAD;
          end
        end
        LOAD: begin
          // Strobes seen here are dropped
          cnt <= cnt + 1'b1;
          if (cnt == UpdateCntW'(UpdateLatency - 2)) begin
            update_out <= 1'b1; // Every pipeline now runs on the new settings
            state      <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // The pulse ends the load, so a second pulse needs a fresh accepted strobe
  a_update_single: assert property (
    @(posedge CLK) disable iff (!rst_n)
    update_out |=> !update_out
  ) else $error("update_out high in two consecutive cycles");

  a_update_spacing: assert property (
    @(posedge CLK) disable iff (!rst_n)
    (state == IDLE && update_in) |-> ##UpdateLatency update_out
  ) else $error("update_out missing after accepted update");

endmodule

`default_nettype wire

// ==== hw/div_48_24.sv ====
`default_nettype none

module div_48_24 import mod_pkg::*; (
  input  logic     CLK,
  input  logic     rst_n,
  input  div_in_t  din,
  output div_out_t dout
);

  // Stage k holds the state after k quotient bits
  logic [DivisorW-1:0]  rem_q [1:DividendW];
  logic [DividendW-1:0] dq_q  [0:DividendW]; // Dividend bits shift out as quotient bits shift in
  logic [DivisorW-1:0]  dvs_q [0:DividendW-1];
  logic [DividendW:0]   vld_q;

  always_ff @(posedge CLK) begin
    dq_q[0]  <= din.dividend;
    dvs_q[0] <= din.divisor;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[DividendW-1:0], din.valid};
    end
  end

  for (genvar k = 0; k < DividendW; k++) begin : gen_stage
    logic [DivisorW:0] trial;
    logic [DivisorW:0] diff;
    logic q_bit;

    if (k == 0) begin : gen_first
      assign trial = {{DivisorW{1'b0}}, dq_q[0][DividendW-1]}; // Partial remainder starts at 0
    end else begin : gen_next
      assign trial = {rem_q[k], dq_q[k][DividendW-1]};
    end
    assign diff  = trial - {1'b0, dvs_q[k]};
    // A zero divisor always subtracts, which gives the all-ones quotient
    assign q_bit = (trial >= {1'b0, dvs_q[k]});

    always_ff @(posedge CLK) begin
      rem_q[k+1] <= q_bit ? diff[DivisorW-1:0] : trial[DivisorW-1:0];
      dq_q[k+1]  <= {dq_q[k][DividendW-2:0], q_bit};
    end

    if (k < DividendW - 1) begin : gen_fwd
      always_ff @(posedge CLK) begin
        dvs_q[k+1] <= dvs_q[k];
      end
    end
  end

  assign dout.quo   = dq_q[DividendW];
  assign dout.rem   = rem_q[DividendW];
  assign dout.valid = vld_q[DividendW];

  // Only checked once the window back to the input is free of reset
  a_valid_latency: assert property (
    @(posedge CLK)
    rst_n [*DivLatency + 1] |-> (dout.valid == $past(din.valid, DivLatency))
  ) else $error("divider valid does not match input valid delayed by DivLatency");

endmodule

`default_nettype wire

// ==== hw/mod_idx_calc.sv ====
`default_nettype none

module mod_idx_calc import mod_pkg::*; (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic [SysTimeW-1:0] sys_time,
  input  seg_setting_t        setting,
  output logic [IdxW-1:0]     idx
);

  div_in_t  cnt_in;
  div_out_t cnt_out;
  div_in_t  idx_in;
  div_out_t idx_out;
  logic [IdxW:0] cycle_len; // One bit wider so a cycle of all ones still fits

  assign cycle_len = {1'b0, setting.cycle} + 1'b1;

  // Modulation tick count, then position within the cycle
  assign cnt_in.dividend = sys_time[SysTimeW-1:TimeShift];
  assign cnt_in.divisor  = DivisorW'(setting.freq_div);
  assign cnt_in.valid    = 1'b1;

  div_48_24 u_div_cnt (
    .CLK   (CLK),
    .rst_n (rst_n),
    .din   (cnt_in),
    .dout  (cnt_out)
  );

  assign idx_in.dividend = cnt_out.quo;
  assign idx_in.divisor  = DivisorW'(cycle_len);
  assign idx_in.valid    = cnt_out.valid; // High in steady state, keeps unflushed data out

  div_48_24 u_div_idx (
    .CLK   (CLK),
    .rst_n (rst_n),
    .din   (idx_in),
    .dout  (idx_out)
  );

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      idx <= '0;
    end else if (idx_out.valid) begin
      idx <= idx_out.rem[IdxW-1:0];
    end
  end

  // The remainder is always below cycle + 1, so the kept low bits are exact
  a_idx_in_range: assert property (
    @(posedge CLK) disable iff (!rst_n)
    $past(idx_out.valid) |-> ({1'b0, idx} < $past(cycle_len, 1))
      || $past(setting) != $past(setting, DivLatency + 1)
  ) else $error("index outside its cycle length");

endmodule

`default_nettype wire

// ==== hw/mod_idx_select.sv ====
`default_nettype none

module mod_idx_select import mod_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n,
  input  idx_arr_t        idx,
  input  seg_sel_t        segment_req,
  output seg_sel_t        segment,
  output logic [IdxW-1:0] idx_active
);

  seg_sel_t req_q;          // Request noted at the last edge
  logic pend;
  logic [IdxW-1:0] req_idx;
  seg_sel_t seg_next;

  assign req_idx = idx[req_q];

  // Switch only at the wrap of the requested segment so the sequence stays whole
  always_comb begin
    seg_next = segment;
    if (pend && req_idx == '0) begin
      seg_next = req_q;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      segment    <= '0;
      req_q      <= '0;
      pend       <= 1'b0;
      idx_active <= '0;
    end else begin
      segment    <= seg_next;
      idx_active <= idx[seg_next]; // New segment shows from the switching edge
      req_q      <= segment_req;
      pend       <= (segment_req != seg_next);
    end
  end

  a_switch_on_wrap: assert property (
    @(posedge CLK) disable iff (!rst_n)
    $changed(segment) |-> ($past(req_idx) == '0) && (segment == $past(req_q))
  ) else $error("segment changed away from a wrap of the requested index");

endmodule

`default_nettype wire

// ==== hw/modulation_timer.sv ====
`default_nettype none

module modulation_timer import mod_pkg::*; (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic [SysTimeW-1:0] sys_time,
  input  logic                update_in,
  input  seg_setting_arr_t    settings_in,
  input  seg_sel_t            segment_req,
  output logic                update_out,
  output idx_arr_t            idx,
  output seg_sel_t            segment,
  output logic [IdxW-1:0]     idx_active
);

  seg_setting_arr_t settings;

  mod_settings u_settings (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .update_in   (update_in),
    .settings_in (settings_in),
    .settings    (settings),
    .update_out  (update_out)
  );

  // One index pipeline per segment, all fed the same system time
  for (genvar i = 0; i < NumSegment; i++) begin : gen_seg
    mod_idx_calc u_calc (
      .CLK      (CLK),
      .rst_n    (rst_n),
      .sys_time (sys_time),
      .setting  (settings[i]),
      .idx      (idx[i])
    );
  end

  mod_idx_select u_select (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .idx         (idx),
    .segment_req (segment_req),
    .segment     (segment),
    .idx_active  (idx_active)
  );

endmodule

`default_nettype wire

// ==== bench/tb_modulation_timer.sv ====
`default_nettype none

module tb_modulation_timer import mod_pkg::*;;

  localparam int ClkPeriod = 8;
  localparam int DriveDelay = 1;
  localparam int RunCycles = 300;
  localparam int NumRandUpdates = 6;
  localparam int SegWaitMax = 2000;
  localparam int UpdCycles = 2 + UpdateLatency + RunCycles;
  localparam int TotalCycles = 3 + 150 + 9 + (4 + NumRandUpdates) * UpdCycles
                               + 2 * (SegWaitMax + 40) + 20;

  logic                CLK = 1'b0;
  logic                rst_n;
  logic [SysTimeW-1:0] sys_time;
  logic                update_in;
  seg_setting_arr_t    settings_in;
  seg_sel_t            segment_req;
  logic                update_out;
  idx_arr_t            idx;
  seg_sel_t            segment;
  logic [IdxW-1:0]     idx_active;

  logic [31:0]         rng = 32'h8bd2;
  logic [SysTimeW-1:0] hist [$];   // Time samples still inside the pipeline
  seg_setting_arr_t    model_set = '0;
  seg_setting_arr_t    pend_set = '0;
  idx_arr_t            exp_idx;
  int                  load_left = -1; // Edges until the pulse, -1 when idle
  logic                check_on = 1'b1;
  logic                pulse_due;
  seg_sel_t            model_seg = '0;
  seg_sel_t            noted_req = '0;
  logic                pending = 1'b0;
  logic [IdxW-1:0]     model_active = '0;
  logic                active_known = 1'b1;
  logic                prev_rst = 1'b0;

  modulation_timer DUT (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .sys_time    (sys_time),
    .update_in   (update_in),
    .settings_in (settings_in),
    .segment_req (segment_req),
    .update_out  (update_out),
    .idx         (idx),
    .segment     (segment),
    .idx_active  (idx_active)
  );

  always #(ClkPeriod / 2) CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic seg_setting_t random_setting();
    seg_setting_t s;
    s.freq_div = IdxW'(next_rand());
    if (next_rand() % 2 == 0) begin
      s.freq_div = IdxW'(next_rand() % 16 + 1); // Short periods so indices wrap often
    end
    if (s.freq_div == '0) begin
      s.freq_div = IdxW'(1);
    end
    s.cycle = (next_rand() % 3 == 0) ? IdxW'(next_rand()) : IdxW'(next_rand() % 32);
    return s;
  endfunction

  // Tick count divided by the divider, then taken modulo cycle plus one
  function automatic logic [IdxW-1:0] expected_index(input logic [SysTimeW-1:0] t,
                                                     input seg_setting_t s);
    logic [63:0] ticks;
    logic [63:0] count;
    logic [63:0] len;
    ticks = 64'(t >> TimeShift);
    if (s.freq_div == '0) begin
      count = (64'd1 << DividendW) - 64'd1; // Zero divisor yields an all-ones quotient
    end else begin
      count = ticks / 64'(s.freq_div);
    end
    len = 64'(s.cycle) + 64'd1;
    return IdxW'(count % len);
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: %s is 'h%0h, expected 'h%0h",
                              $time, name, got, exp));
    end
  endtask

  task automatic tick();
    @(posedge CLK);
    #DriveDelay;
    sys_time = sys_time + SysTimeW'((next_rand() % 4 + 1) * 512);
  endtask

  task automatic run_cycles(input int n);
    repeat (n) tick();
  endtask

  task automatic send_update(input seg_setting_arr_t s);
    tick();
    update_in   = 1'b1;
    settings_in = s;
    tick();
    update_in   = 1'b0;
  endtask

  task automatic wait_update();
    int n;
    n = 0;
    while (!update_out && n < UpdateLatency + 4) begin
      @(negedge CLK);
      n++;
    end
    if (!update_out) begin
      stop_on_error("update_out never arrived after an accepted update");
    end
  endtask

  task automatic load_and_run(input seg_setting_arr_t s);
    send_update(s);
    wait_update();
    run_cycles(RunCycles);
  endtask

  task automatic wait_segment(input seg_sel_t want);
    int n;
    n = 0;
    while (segment != want && n < SegWaitMax) begin
      @(negedge CLK);
      n++;
    end
    if (segment != want) begin
      stop_on_error("segment never switched to the requested value");
    end
  endtask

  // Outputs seen here come from the last rising edge, inputs here go to the next one
  always @(negedge CLK) begin
    if (load_left > 0) begin
      load_left = load_left - 1;
    end
    pulse_due = (load_left == 0);
    if (pulse_due) begin
      model_set = pend_set;
      check_on  = 1'b1;
      load_left = -1;
    end
    for (int s = 0; s < NumSegment; s++) begin
      exp_idx[s] = (hist.size() == IdxLatency) ? expected_index(hist[0], model_set[s]) : '0;
    end
    if (prev_rst) begin
      if (pulse_due && !update_out) begin
        stop_on_error($sformatf("update_out did not pulse %0d cycles after the accepted update",
                                UpdateLatency));
      end
      if (!pulse_due && update_out) begin
        stop_on_error("update_out pulsed although no accepted update was due");
      end
      if (check_on) begin
        for (int s = 0; s < NumSegment; s++) begin
          check_value($sformatf("idx[%0d]", s), 64'(idx[s]), 64'(exp_idx[s]));
        end
      end
      check_value("segment", 64'(segment), 64'(model_seg));
      if (active_known) begin
        check_value("idx_active", 64'(idx_active), 64'(model_active));
      end
    end
    if (!rst_n) begin
      model_seg    = '0;
      noted_req    = '0;
      pending      = 1'b0;
      model_active = '0;
      active_known = 1'b1;
      load_left    = -1;
    end else begin
      if (pending && !check_on) begin
        stop_on_error("segment request still pending while new settings load");
      end
      if (pending && exp_idx[noted_req] == '0) begin
        model_seg = noted_req; // Requested segment wraps at this edge
      end
      model_active = exp_idx[model_seg];
      active_known = check_on;
      noted_req    = segment_req;
      pending      = (segment_req != model_seg);
      if (update_in && load_left < 0) begin
        pend_set  = settings_in;
        load_left = UpdateLatency;
        check_on  = 1'b0;
      end
    end
    prev_rst = rst_n;
    hist.push_back(sys_time);
    if (hist.size() > IdxLatency) begin
      void'(hist.pop_front());
    end
  end

  initial begin : watchdog
    #((TotalCycles + 500) * ClkPeriod);
    stop_on_error("watchdog timeout, the test sequence did not finish in time");
  end

  initial begin : stimulus
    seg_setting_arr_t s;
    rst_n       = 1'b0;
    sys_time    = '0;
    update_in   = 1'b0;
    settings_in = '0;
    segment_req = '0;
    sys_time    = {25'(next_rand()), next_rand()};
    repeat (3) tick();
    rst_n = 1'b1;
    run_cycles(150); // Reset settings hold every index at 0

    // The second strobe lands while loading and has to be dropped
    s[0] = random_setting();
    s[1] = random_setting();
    send_update(s);
    run_cycles(5);
    s[1].cycle = ~s[1].cycle;
    send_update(s);
    wait_update();
    run_cycles(RunCycles);

    s[0].freq_div = IdxW'(1);
    s[0].cycle    = IdxW'(next_rand() % 64);
    s[1]          = random_setting();
    s[1].cycle    = '0;
    load_and_run(s);

    s[0].freq_div = '0;
    s[0].cycle    = IdxW'(7);
    s[1].freq_div = '0;
    s[1].cycle    = IdxW'(next_rand());
    load_and_run(s);

    // Short cycles so the requested segment wraps soon
    s[0].freq_div = IdxW'(2);
    s[0].cycle    = IdxW'(5);
    s[1].freq_div = IdxW'(1);
    s[1].cycle    = IdxW'(9);
    send_update(s);
    wait_update();
    run_cycles(20);
    segment_req = seg_sel_t'(1);
    wait_segment(seg_sel_t'(1));
    run_cycles(40);
    segment_req = '0;
    wait_segment('0);
    run_cycles(40);

    for (int i = 0; i < NumRandUpdates; i++) begin
      s[0] = random_setting();
      s[1] = random_setting();
      load_and_run(s);
    end

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
hw/mod_pkg.sv
hw/mod_settings.sv
hw/div_48_24.sv
hw/mod_idx_calc.sv
hw/mod_idx_select.sv
hw/modulation_timer.sv
bench/tb_modulation_timer.sv

// ==== Makefile ====
# Verilator build and run for the modulation timer testbench

VERILATOR  ?= verilator
TOP        ?= tb_modulation_timer
RTL_TOP    ?= modulation_timer
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
